// File: source/pito_pkg.sv
package pito_pkg;

    // ====================
    // widths and sizes
    // ====================
    localparam int xlen = 32;

    // defaults picked up by the top level
    localparam int num_harts_dflt = 8;
    localparam int imem_depth     = 1024;
    localparam int dmem_depth     = 1024;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // ====================
    // instruction fields
    // ====================
    // major opcodes, bits 6:0
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // funct3, bits 14:12
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    // funct7, bits 31:25
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // decoded instruction, unknown encodings land on nop
    typedef enum logic [4:0] {
        RV32_NOP, RV32_ADD, RV32_SUB, RV32_AND, RV32_OR, RV32_XOR, RV32_SLT,
        RV32_SLL, RV32_SRL, RV32_SRA, RV32_ADDI, RV32_ANDI, RV32_ORI, RV32_XORI,
        RV32_SLLI, RV32_SRLI, RV32_LUI, RV32_LW, RV32_SW, RV32_BEQ, RV32_BNE,
        RV32_JAL
    } rv32_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_PASS_B
    } rv32_alu_op_e;

endpackage

// File: source/rv32_decoder.sv
module rv32_decoder import pito_pkg::*; (
    input  word_t        instr,
    output rv32_opcode_e opcode,
    output rv32_alu_op_e alu_op,
    output reg_addr_t    rs1,
    output reg_addr_t    rs2,
    output reg_addr_t    rd,
    output word_t        imm,
    output logic [4:0]   shamt
);

    logic [6:0] major;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // raw fields
    assign major = instr[6:0];
    assign f3    = instr[14:12];
    assign f7    = instr[31:25];
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];
    assign rd    = instr[11:7];
    assign shamt = instr[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // major opcode plus function fields
    always_comb begin
        opcode = RV32_NOP;
        case (major)
            opc_op: begin
                case ({f7, f3})
                    {f7_base, f3_add_sub}: opcode = RV32_ADD;
                    {f7_alt,  f3_add_sub}: opcode = RV32_SUB;
                    {f7_base, f3_sll}:     opcode = RV32_SLL;
                    {f7_base, f3_slt}:     opcode = RV32_SLT;
                    {f7_base, f3_xor}:     opcode = RV32_XOR;
                    {f7_base, f3_srl_sra}: opcode = RV32_SRL;
                    {f7_alt,  f3_srl_sra}: opcode = RV32_SRA;
                    {f7_base, f3_or}:      opcode = RV32_OR;
                    {f7_base, f3_and}:     opcode = RV32_AND;
                    default:               opcode = RV32_NOP;
                endcase
            end
            opc_op_imm: begin
                case (f3)
                    f3_add_sub: opcode = RV32_ADDI;
                    f3_and:     opcode = RV32_ANDI;
                    f3_or:      opcode = RV32_ORI;
                    f3_xor:     opcode = RV32_XORI;
                    // shifts by immediate need a clean funct7
                    f3_sll:     opcode = (f7 == f7_base) ? RV32_SLLI : RV32_NOP;
                    f3_srl_sra: opcode = (f7 == f7_base) ? RV32_SRLI : RV32_NOP;
                    default:    opcode = RV32_NOP;
                endcase
            end
            opc_lui:    opcode = RV32_LUI;
            opc_load:   opcode = (f3 == f3_word) ? RV32_LW : RV32_NOP;
            opc_store:  opcode = (f3 == f3_word) ? RV32_SW : RV32_NOP;
            opc_branch: begin
                case (f3)
                    f3_beq:  opcode = RV32_BEQ;
                    f3_bne:  opcode = RV32_BNE;
                    default: opcode = RV32_NOP;
                endcase
            end
            opc_jal:    opcode = RV32_JAL;
            default:    opcode = RV32_NOP;
        endcase
    end

    // alu operation per instruction
    always_comb begin
        case (opcode)
            RV32_ADD, RV32_ADDI, RV32_LW, RV32_SW: alu_op = ALU_ADD;
            // branches compare through sub and the zero flag
            RV32_SUB, RV32_BEQ, RV32_BNE:          alu_op = ALU_SUB;
            RV32_AND, RV32_ANDI:                   alu_op = ALU_AND;
            RV32_OR, RV32_ORI:                     alu_op = ALU_OR;
            RV32_XOR, RV32_XORI:                   alu_op = ALU_XOR;
            RV32_SLT:                              alu_op = ALU_SLT;
            RV32_SLL, RV32_SLLI:                   alu_op = ALU_SLL;
            RV32_SRL, RV32_SRLI:                   alu_op = ALU_SRL;
            RV32_SRA:                              alu_op = ALU_SRA;
            default:                               alu_op = ALU_PASS_B;
        endcase
    end

    // immediate format per instruction
    always_comb begin
        case (opcode)
            RV32_LUI:           imm = imm_u;
            RV32_SW:            imm = imm_s;
            RV32_BEQ, RV32_BNE: imm = imm_b;
            RV32_JAL:           imm = imm_j;
            default:            imm = imm_i;
        endcase
    end

endmodule

// File: source/rv32_alu.sv
module rv32_alu import pito_pkg::*; (
    input  word_t        a,
    input  word_t        b,
    input  rv32_alu_op_e op,
    output word_t        res,
    output logic         z
);

    logic [4:0] sh;

    // only the low five bits shift
    assign sh = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_AND:    res = a & b;
            ALU_OR:     res = a | b;
            ALU_XOR:    res = a ^ b;
            // signed compare
            ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL:    res = a << sh;
            ALU_SRL:    res = a >> sh;
            ALU_SRA:    res = word_t'($signed(a) >>> sh);
            default:    res = b;
        endcase
    end

    // beq and bne look at this after a sub
    assign z = (res == '0);

endmodule

// File: source/rv32_barrel_regfiles.sv
module rv32_barrel_regfiles import pito_pkg::*; #(
    parameter int num_harts = 8,
    localparam type hart_t = logic [$clog2(num_harts)-1:0]
) (
    input  logic      clk,
    input  hart_t     rd_hart,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  logic      wen,
    input  hart_t     wr_hart,
    input  reg_addr_t wa,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);

    // one bank of 32 per hart
    word_t regs [num_harts][32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wen && (wa != '0)) begin
            regs[wr_hart][wa] <= wd;
        end
    end

    // combinational read, x0 reads zero
    assign rd1 = (ra1 == '0) ? '0 : regs[rd_hart][ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[rd_hart][ra2];

endmodule

// File: source/rv32_memory.sv
module rv32_memory import pito_pkg::*; #(
    parameter int depth = 1024,
    localparam int aw = $clog2(depth)
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [aw-1:0] wr_addr,
    input  logic [aw-1:0] rd_addr,
    input  word_t         wr_data,
    output word_t         rd_data
);

    word_t mem [depth];

    // registered read, old word on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/rv32_fetch.sv
module rv32_fetch import pito_pkg::*; #(
    parameter int num_harts  = 8,
    parameter int slot_words = 128,
    localparam type hart_t = logic [$clog2(num_harts)-1:0]
) (
    input  logic  clk,
    input  logic  pito_io_rst_n,
    input  logic  pc_load,
    input  hart_t pc_load_hart,
    input  word_t pc_load_target,
    input  logic  pc_load_taken,
    output word_t imem_addr,
    output hart_t fetch_hart,
    output word_t fetch_pc
);

    hart_t hart_cnt;
    word_t pc [num_harts];

    // ====================
    // round robin harts
    // ====================
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            hart_cnt <= '0;
            // each hart starts at the base of its own slot
            for (int h = 0; h < num_harts; h++) begin
                pc[h] <= word_t'(h * slot_words * 4);
            end
        end else begin
            hart_cnt <= hart_cnt + 1'b1;
            // result of the last instruction of that hart
            if (pc_load) begin
                if (pc_load_taken) begin
                    pc[pc_load_hart] <= pc_load_target;
                end else begin
                    pc[pc_load_hart] <= pc[pc_load_hart] + 32'd4;
                end
            end
        end
    end

    assign fetch_hart = hart_cnt;
    assign fetch_pc   = pc[hart_cnt];
    // word address into the instruction memory
    assign imem_addr  = {2'b00, pc[hart_cnt][xlen-1:2]};

endmodule

// File: source/rv32_next_pc.sv
module rv32_next_pc import pito_pkg::*; (
    input  rv32_opcode_e opcode,
    input  logic         alu_z,
    input  word_t        pc,
    input  word_t        imm,
    output logic         taken,
    output word_t        target,
    output word_t        link
);

    // taken from the sub result, jal always
    always_comb begin
        case (opcode)
            RV32_BEQ: taken = alu_z;
            RV32_BNE: taken = !alu_z;
            RV32_JAL: taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    // pc relative target
    assign target = pc + imm;
    // return address for jal
    assign link   = pc + 32'd4;

endmodule

// File: source/rv32_core.sv
module rv32_core import pito_pkg::*; #(
    parameter int num_harts  = num_harts_dflt,
    parameter int imem_words = imem_depth,
    parameter int dmem_words = dmem_depth,
    parameter int slot_words = imem_words / num_harts,
    localparam int iaw = $clog2(imem_words),
    localparam int daw = $clog2(dmem_words),
    localparam type hart_t = logic [$clog2(num_harts)-1:0]
) (
    input  logic           clk,
    input  logic           pito_io_rst_n,
    input  logic [iaw-1:0] pito_io_imem_addr,
    input  word_t          pito_io_imem_data,
    input  logic           pito_io_imem_w_en,
    input  logic [daw-1:0] pito_io_dmem_addr,
    input  word_t          pito_io_dmem_data,
    input  logic           pito_io_dmem_w_en,
    input  logic           pito_io_program,
    output word_t          pito_io_dmem_rdata
);

    // fetch
    word_t        f_imem_addr;
    hart_t        f_hart;
    word_t        f_pc;
    word_t        instr;
    // decode
    logic         dec_valid;
    hart_t        dec_hart;
    word_t        dec_pc;
    rv32_opcode_e dec_opcode;
    rv32_alu_op_e dec_alu_op;
    reg_addr_t    dec_rs1;
    reg_addr_t    dec_rs2;
    reg_addr_t    dec_rd;
    word_t        dec_imm;
    logic [4:0]   dec_shamt;
    word_t        dec_b;
    word_t        rf_rd1;
    word_t        rf_rd2;
    // execute
    logic         ex_valid;
    hart_t        ex_hart;
    word_t        ex_pc;
    rv32_opcode_e ex_opcode;
    rv32_alu_op_e ex_alu_op;
    word_t        ex_a;
    word_t        ex_b;
    word_t        ex_rs2v;
    word_t        ex_imm;
    reg_addr_t    ex_rd;
    word_t        alu_res;
    logic         alu_z;
    // write back
    logic         wb_valid;
    logic         wb_st_en;
    hart_t        wb_hart;
    word_t        wb_pc;
    rv32_opcode_e wb_opcode;
    word_t        wb_res;
    logic         wb_z;
    word_t        wb_imm;
    reg_addr_t    wb_rd;
    word_t        wb_st_data;
    logic         wb_writes;
    word_t        wb_wd;
    logic         npc_taken;
    word_t        npc_target;
    word_t        npc_link;
    // register write
    logic         rw_valid;
    logic         rw_wen;
    hart_t        rw_hart;
    logic         rw_taken;
    word_t        rw_target;
    reg_addr_t    rw_wa;
    logic         rw_is_load;
    word_t        rw_wd;
    word_t        rf_wd;
    // data memory ports after the io mux
    logic         dm_wr_en;
    logic [daw-1:0] dm_wr_addr;
    logic [daw-1:0] dm_rd_addr;
    word_t        dm_wr_data;

    rv32_fetch #(.num_harts(num_harts), .slot_words(slot_words)) fetch (
        .clk, .pito_io_rst_n,
        .pc_load(rw_valid), .pc_load_hart(rw_hart),
        .pc_load_target(rw_target), .pc_load_taken(rw_taken),
        .imem_addr(f_imem_addr), .fetch_hart(f_hart), .fetch_pc(f_pc)
    );

    // io writes the program at any time, the core only reads
    rv32_memory #(.depth(imem_words)) i_mem (
        .clk, .wr_en(pito_io_imem_w_en), .wr_addr(pito_io_imem_addr),
        .rd_addr(f_imem_addr[iaw-1:0]), .wr_data(pito_io_imem_data), .rd_data(instr)
    );

    rv32_decoder decoder (
        .instr, .opcode(dec_opcode), .alu_op(dec_alu_op), .rs1(dec_rs1), .rs2(dec_rs2),
        .rd(dec_rd), .imm(dec_imm), .shamt(dec_shamt)
    );

    rv32_barrel_regfiles #(.num_harts(num_harts)) regfile (
        .clk, .rd_hart(dec_hart), .ra1(dec_rs1), .ra2(dec_rs2),
        .wen(rw_wen), .wr_hart(rw_hart), .wa(rw_wa), .wd(rf_wd),
        .rd1(rf_rd1), .rd2(rf_rd2)
    );

    rv32_alu alu (.a(ex_a), .b(ex_b), .op(ex_alu_op), .res(alu_res), .z(alu_z));

    rv32_next_pc next_pc (
        .opcode(wb_opcode), .alu_z(wb_z), .pc(wb_pc), .imm(wb_imm),
        .taken(npc_taken), .target(npc_target), .link(npc_link)
    );

    // ====================
    // pipeline control
    // ====================
    // fetches made in program mode never retire
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            dec_valid <= 1'b0;
            ex_valid  <= 1'b0;
            wb_valid  <= 1'b0;
            wb_st_en  <= 1'b0;
            rw_valid  <= 1'b0;
            rw_wen    <= 1'b0;
        end else begin
            dec_valid <= !pito_io_program;
            ex_valid  <= dec_valid;
            wb_valid  <= ex_valid;
            wb_st_en  <= ex_valid && (ex_opcode == RV32_SW);
            rw_valid  <= wb_valid;
            rw_wen    <= wb_valid && wb_writes && (wb_rd != '0);
        end
    end

    // ====================
    // decode to execute
    // ====================
    // operand b: register, shift amount or immediate
    always_comb begin
        case (dec_opcode)
            RV32_ADD, RV32_SUB, RV32_AND, RV32_OR, RV32_XOR, RV32_SLT, RV32_SLL,
            RV32_SRL, RV32_SRA, RV32_BEQ, RV32_BNE: dec_b = rf_rd2;
            RV32_SLLI, RV32_SRLI:                   dec_b = {27'b0, dec_shamt};
            default:                                dec_b = dec_imm;
        endcase
    end

    always_ff @(posedge clk) begin
        dec_hart  <= f_hart;
        dec_pc    <= f_pc;
        ex_hart   <= dec_hart;
        ex_pc     <= dec_pc;
        ex_opcode <= dec_opcode;
        ex_alu_op <= dec_alu_op;
        ex_a      <= rf_rd1;
        ex_b      <= dec_b;
        ex_rs2v   <= rf_rd2;
        ex_imm    <= dec_imm;
        ex_rd     <= dec_rd;
    end

    // ====================
    // execute to write back
    // ====================
    // alu result doubles as the load and store address
    always_ff @(posedge clk) begin
        wb_hart    <= ex_hart;
        wb_pc      <= ex_pc;
        wb_opcode  <= ex_opcode;
        wb_res     <= alu_res;
        wb_z       <= alu_z;
        wb_imm     <= ex_imm;
        wb_rd      <= ex_rd;
        wb_st_data <= ex_rs2v;
    end

    // io owns the data memory in program mode
    assign dm_wr_en   = pito_io_program ? pito_io_dmem_w_en : wb_st_en;
    assign dm_wr_addr = pito_io_program ? pito_io_dmem_addr : wb_res[daw+1:2];
    assign dm_rd_addr = pito_io_program ? pito_io_dmem_addr : wb_res[daw+1:2];
    assign dm_wr_data = pito_io_program ? pito_io_dmem_data : wb_st_data;

    rv32_memory #(.depth(dmem_words)) d_mem (
        .clk, .wr_en(dm_wr_en), .wr_addr(dm_wr_addr), .rd_addr(dm_rd_addr),
        .wr_data(dm_wr_data), .rd_data(pito_io_dmem_rdata)
    );

    // stores and branches leave the register file alone
    assign wb_writes = !((wb_opcode == RV32_SW) || (wb_opcode == RV32_BEQ) ||
                         (wb_opcode == RV32_BNE) || (wb_opcode == RV32_NOP));

    always_comb begin
        case (wb_opcode)
            RV32_LUI: wb_wd = wb_imm;
            RV32_JAL: wb_wd = npc_link;
            default:  wb_wd = wb_res;
        endcase
    end

    // ====================
    // register write
    // ====================
    always_ff @(posedge clk) begin
        rw_hart    <= wb_hart;
        rw_taken   <= npc_taken;
        rw_target  <= npc_target;
        rw_wa      <= wb_rd;
        rw_is_load <= (wb_opcode == RV32_LW);
        rw_wd      <= wb_wd;
    end

    // load data shows up one clock after its address
    assign rf_wd = rw_is_load ? pito_io_dmem_rdata : rw_wd;

endmodule

// File: tests/rv32_core_chk.sv
module rv32_core_chk import pito_pkg::*; #(
    parameter int num_harts = 8,
    localparam type hart_t = logic [$clog2(num_harts)-1:0]
) (
    input logic      clk,
    input logic      rst_n,
    input hart_t     hart,
    input logic      st_en,
    input logic      rf_wen,
    input reg_addr_t rf_wa
);

    timeunit 1ns;
    timeprecision 1ns;

    // round robin, one step per clock
    hart_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (hart == hart_t'($past(hart) + 1'b1)))
        else $error("hart counter did not advance by one");

    // no store right out of reset
    store_idle: assert property (@(posedge clk) $rose(rst_n) |-> !st_en)
        else $error("data write enable high in the first cycle after reset");

    // x0 never written
    x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rf_wen |-> (rf_wa != '0))
        else $error("register write aimed at x0");

endmodule

bind rv32_core rv32_core_chk #(.num_harts(num_harts)) chk (
    .clk    (clk),
    .rst_n  (pito_io_rst_n),
    .hart   (f_hart),
    .st_en  (wb_st_en),
    .rf_wen (rw_wen),
    .rf_wa  (rw_wa)
);

// File: tests/rv32_core_tb.sv
module rv32_core_tb import pito_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    // ====================
    // sizes
    // ====================
    localparam int num_harts  = 8;
    localparam int imem_words = 1024;
    localparam int dmem_words = 1024;
    localparam int iaw        = 10;
    localparam int daw        = 10;
    localparam int slot_words = imem_words / num_harts;
    // data words owned by one hart
    localparam int region     = dmem_words / num_harts;
    // setup 0..8, random body 9..32, register dump 33..39, self loop 40
    localparam int prog_len   = 41;
    localparam int body_start = 9;
    localparam int dump_start = 33;
    localparam int run_cycles = 60 * num_harts;
    localparam int load_cycles = num_harts * prog_len + dmem_words + 8;
    localparam int read_cycles = dmem_words + 2;
    localparam int max_cycles  = 2 * (8 + load_cycles + 2 * read_cycles + run_cycles);

    localparam rv32_opcode_e alu_ops [15] = '{
        RV32_ADD, RV32_SUB, RV32_AND, RV32_OR, RV32_XOR, RV32_SLT, RV32_SLL, RV32_SRL,
        RV32_SRA, RV32_ADDI, RV32_ANDI, RV32_ORI, RV32_XORI, RV32_SLLI, RV32_SRLI
    };

    logic           clk;
    logic           rst_n;
    logic [iaw-1:0] imem_addr;
    word_t          imem_data;
    logic           imem_w_en;
    logic [daw-1:0] dmem_addr;
    word_t          dmem_data;
    logic           dmem_w_en;
    logic           prog_mode;
    word_t          dmem_rdata;

    // generated programs, fields and encoded words
    rv32_opcode_e p_op   [num_harts][prog_len];
    int           p_rd   [num_harts][prog_len];
    int           p_rs1  [num_harts][prog_len];
    int           p_rs2  [num_harts][prog_len];
    int           p_imm  [num_harts][prog_len];
    word_t        p_word [num_harts][prog_len];

    // reference state
    word_t mem_init  [dmem_words];
    word_t mem_model [dmem_words];
    word_t regs_model [32];

    int seed = 17;
    int errors;
    int checks;
    int cycles;

    rv32_core DUT (
        .clk                (clk),
        .pito_io_rst_n      (rst_n),
        .pito_io_imem_addr  (imem_addr),
        .pito_io_imem_data  (imem_data),
        .pito_io_imem_w_en  (imem_w_en),
        .pito_io_dmem_addr  (dmem_addr),
        .pito_io_dmem_data  (dmem_data),
        .pito_io_dmem_w_en  (dmem_w_en),
        .pito_io_program    (prog_mode),
        .pito_io_dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit from the length of all phases
    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", max_cycles);
        $display("TB FAILED");
        $finish;
    end

    // ====================
    // helpers
    // ====================
    function automatic int urand(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // rv32 encoding straight from the isa formats
    function automatic word_t encode(input rv32_opcode_e op, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2,
                                     input int imm);
        logic [31:0] im;
        word_t       w;
        im = imm;
        case (op)
            RV32_ADD:  w = {f7_base, rs2, rs1, f3_add_sub, rd, opc_op};
            RV32_SUB:  w = {f7_alt, rs2, rs1, f3_add_sub, rd, opc_op};
            RV32_AND:  w = {f7_base, rs2, rs1, f3_and, rd, opc_op};
            RV32_OR:   w = {f7_base, rs2, rs1, f3_or, rd, opc_op};
            RV32_XOR:  w = {f7_base, rs2, rs1, f3_xor, rd, opc_op};
            RV32_SLT:  w = {f7_base, rs2, rs1, f3_slt, rd, opc_op};
            RV32_SLL:  w = {f7_base, rs2, rs1, f3_sll, rd, opc_op};
            RV32_SRL:  w = {f7_base, rs2, rs1, f3_srl_sra, rd, opc_op};
            RV32_SRA:  w = {f7_alt, rs2, rs1, f3_srl_sra, rd, opc_op};
            RV32_ADDI: w = {im[11:0], rs1, f3_add_sub, rd, opc_op_imm};
            RV32_ANDI: w = {im[11:0], rs1, f3_and, rd, opc_op_imm};
            RV32_ORI:  w = {im[11:0], rs1, f3_or, rd, opc_op_imm};
            RV32_XORI: w = {im[11:0], rs1, f3_xor, rd, opc_op_imm};
            RV32_SLLI: w = {f7_base, im[4:0], rs1, f3_sll, rd, opc_op_imm};
            RV32_SRLI: w = {f7_base, im[4:0], rs1, f3_srl_sra, rd, opc_op_imm};
            RV32_LUI:  w = {im[31:12], rd, opc_lui};
            RV32_LW:   w = {im[11:0], rs1, f3_word, rd, opc_load};
            RV32_SW:   w = {im[11:5], rs2, rs1, f3_word, im[4:0], opc_store};
            RV32_BEQ:  w = {im[12], im[10:5], rs2, rs1, f3_beq, im[4:1], im[11], opc_branch};
            RV32_BNE:  w = {im[12], im[10:5], rs2, rs1, f3_bne, im[4:1], im[11], opc_branch};
            RV32_JAL:  w = {im[20], im[10:1], im[11], im[19:12], rd, opc_jal};
            default:   w = {25'b0, opc_op_imm};
        endcase
        return w;
    endfunction

    task automatic put(input int h, input int i, input rv32_opcode_e op, input int rd,
                       input int rs1, input int rs2, input int imm);
        p_op[h][i]   = op;
        p_rd[h][i]   = rd;
        p_rs1[h][i]  = rs1;
        p_rs2[h][i]  = rs2;
        p_imm[h][i]  = imm;
        p_word[h][i] = encode(op, reg_addr_t'(rd), reg_addr_t'(rs1), reg_addr_t'(rs2), imm);
    endtask

    // ====================
    // program generation
    // ====================
    // x8 holds the region base, x1..x7 carry data
    task automatic gen_program(input int h);
        int i;
        int k;
        int hi;
        int lo;
        int rs1;
        rv32_opcode_e op;
        hi = (h * region * 4 + 2048) >>> 12;
        lo = h * region * 4 - (hi <<< 12);
        put(h, 0, RV32_LUI, 8, 0, 0, hi <<< 12);
        put(h, 1, RV32_ADDI, 8, 8, 0, lo);
        for (k = 1; k < 8; k++) begin
            put(h, k + 1, RV32_ADDI, k, 0, 0, urand(4096) - 2048);
        end
        i = body_start;
        while (i < dump_start) begin
            k = urand(12);
            if (k < 2 && i <= dump_start - 3) begin
                case (urand(3))
                    0:       op = RV32_BEQ;
                    1:       op = RV32_BNE;
                    default: op = RV32_JAL;
                endcase
                rs1 = urand(9);
                // equal operands now and then so beq also gets taken
                put(h, i, op, (op == RV32_JAL) ? urand(8) : 0, rs1,
                    (urand(2) == 0) ? rs1 : urand(9), (2 + urand(2)) * 4);
                // marker store, skipped when the branch is taken
                put(h, i + 1, RV32_SW, 0, 8, urand(9), urand(120) * 4);
                i += 2;
            end else begin
                if (k == 2) begin
                    put(h, i, RV32_LW, 1 + urand(7), 8, 0, urand(120) * 4);
                end else if (k <= 4) begin
                    put(h, i, RV32_SW, 0, 8, urand(9), urand(120) * 4);
                end else if (k == 5) begin
                    put(h, i, RV32_LUI, 1 + urand(7), 0, 0, urand(1 << 20) << 12);
                end else begin
                    k = urand(15);
                    if (k < 9) begin
                        put(h, i, alu_ops[k], 1 + urand(7), urand(9), urand(9), 0);
                    end else if (k < 13) begin
                        put(h, i, alu_ops[k], 1 + urand(7), urand(9), 0, urand(4096) - 2048);
                    end else begin
                        put(h, i, alu_ops[k], 1 + urand(7), urand(9), 0, urand(32));
                    end
                end
                i++;
            end
        end
        // dump x1..x7 to the top of the region
        for (k = 1; k < 8; k++) begin
            put(h, dump_start + k - 1, RV32_SW, 0, 8, k, (120 + k) * 4);
        end
        put(h, prog_len - 1, RV32_JAL, 0, 0, 0, 0);
    endtask

    // ====================
    // instruction set model
    // ====================
    function automatic void write_reg(input int rd, input word_t v);
        if (rd != 0) begin
            regs_model[rd] = v;
        end
    endfunction

    task automatic run_model(input int h);
        int i;
        int steps;
        int next;
        int rd;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        for (i = 0; i < 32; i++) begin
            regs_model[i] = '0;
        end
        i = 0;
        steps = 0;
        // forward flow only, stops at the self loop
        while ((i < prog_len - 1) && (steps < prog_len)) begin
            a    = regs_model[p_rs1[h][i]];
            b    = regs_model[p_rs2[h][i]];
            rd   = p_rd[h][i];
            imm  = word_t'(p_imm[h][i]);
            addr = a + imm;
            next = i + 1;
            case (p_op[h][i])
                RV32_ADD:  write_reg(rd, a + b);
                RV32_SUB:  write_reg(rd, a - b);
                RV32_AND:  write_reg(rd, a & b);
                RV32_OR:   write_reg(rd, a | b);
                RV32_XOR:  write_reg(rd, a ^ b);
                RV32_SLT:  write_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                RV32_SLL:  write_reg(rd, a << b[4:0]);
                RV32_SRL:  write_reg(rd, a >> b[4:0]);
                RV32_SRA:  write_reg(rd, word_t'($signed(a) >>> b[4:0]));
                RV32_ADDI: write_reg(rd, a + imm);
                RV32_ANDI: write_reg(rd, a & imm);
                RV32_ORI:  write_reg(rd, a | imm);
                RV32_XORI: write_reg(rd, a ^ imm);
                RV32_SLLI: write_reg(rd, a << imm[4:0]);
                RV32_SRLI: write_reg(rd, a >> imm[4:0]);
                RV32_LUI:  write_reg(rd, imm);
                RV32_LW:   write_reg(rd, mem_model[addr[11:2]]);
                RV32_SW:   mem_model[addr[11:2]] = b;
                RV32_BEQ:  next = (a == b) ? i + p_imm[h][i] / 4 : i + 1;
                RV32_BNE:  next = (a != b) ? i + p_imm[h][i] / 4 : i + 1;
                RV32_JAL: begin
                    // link is the byte address after the jal in its slot
                    write_reg(rd, word_t'((h * slot_words + i + 1) * 4));
                    next = i + p_imm[h][i] / 4;
                end
                default: ;
            endcase
            i = next;
            steps++;
        end
    endtask

    // ====================
    // io access
    // ====================
    // word a shows up one clock after its address
    task automatic read_back(input bit after_run);
        int a;
        word_t exp;
        for (a = 0; a <= dmem_words; a++) begin
            @(negedge clk);
            if (a > 0) begin
                exp = after_run ? mem_model[a - 1] : mem_init[a - 1];
                checks++;
                if (dmem_rdata !== exp) begin
                    errors++;
                    $display("Mismatch at %0t: dmem word %0d expected %h actual %h",
                             $time, a - 1, exp, dmem_rdata);
                end
            end
            if (a < dmem_words) begin
                dmem_addr = daw'(a);
            end
        end
    endtask

    // ====================
    // test flow
    // ====================
    initial begin
        int h;
        int i;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        prog_mode = 1'b1;
        imem_addr = '0;
        imem_data = '0;
        imem_w_en = 1'b0;
        dmem_addr = '0;
        dmem_data = '0;
        dmem_w_en = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (h = 0; h < num_harts; h++) begin
            gen_program(h);
        end
        for (i = 0; i < dmem_words; i++) begin
            mem_init[i]  = word_t'($random(seed));
            mem_model[i] = mem_init[i];
        end

        // each program into its own slot
        for (h = 0; h < num_harts; h++) begin
            for (i = 0; i < prog_len; i++) begin
                @(negedge clk);
                imem_addr = iaw'(h * slot_words + i);
                imem_data = p_word[h][i];
                imem_w_en = 1'b1;
            end
        end
        @(negedge clk);
        imem_w_en = 1'b0;
        for (i = 0; i < dmem_words; i++) begin
            dmem_addr = daw'(i);
            dmem_data = mem_init[i];
            dmem_w_en = 1'b1;
            @(negedge clk);
        end
        dmem_w_en = 1'b0;

        // idle core, preload must come back as written
        read_back(1'b0);

        for (h = 0; h < num_harts; h++) begin
            run_model(h);
        end

        // all harts at once
        @(negedge clk);
        prog_mode = 1'b0;
        repeat (run_cycles) @(negedge clk);
        prog_mode = 1'b1;

        read_back(1'b1);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/pito_pkg.sv
source/rv32_decoder.sv
source/rv32_alu.sv
source/rv32_barrel_regfiles.sv
source/rv32_memory.sv
source/rv32_fetch.sv
source/rv32_next_pc.sv
source/rv32_core.sv
tests/rv32_core_chk.sv
tests/rv32_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module rv32_core_tb -f files.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vrv32_core_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
